/* all.f */
verilog/rv32i_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/control_unit.sv
verilog/data_path.sv
verilog/rv32i.sv
tb/tb_clock_gen.sv
tb/rv32i_asserts.sv
tb/rv32i_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --timing --assert
TOP   = rv32i_tb
FLIST = all.f
OBJ   = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ)
	@out=$$(./$(OBJ)/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ)

/* tb/rv32i_tb.sv */
`timescale 1ns/1ns

module rv32i_tb import rv32i_pkg::*; ();

    localparam int imem_depth     = 64;
    localparam int dmem_depth     = 256;
    localparam int stores_per_run = 21;
    localparam int timeout_cycles = 400;

    logic            clk;
    logic            arst_n;
    logic [xlen-1:0] current_pc;
    logic [xlen-1:0] inst;
    logic [xlen-1:0] mem_addr_mem;
    logic [xlen-1:0] mem_wdata_mem;
    logic            mem_write_mem;
    logic            mem_read_mem;
    logic [xlen-1:0] mem_rdata_mem;
    logic            stall_pipl;
    logic            if_id_reg_en;

    logic [xlen-1:0] imem [imem_depth];
    logic [xlen-1:0] dmem [dmem_depth];
    logic [xlen-1:0] exp_addr [$];
    logic [xlen-1:0] exp_data [$];
    int              test_last [4] = '{12, 16, 18, 20};
    string           test_name [4] = '{"alu", "forwarding", "load/store", "branch/jal"};

    int          errors      = 0;
    int          stores_seen = 0;
    int          cycles      = 0;
    int          test_idx    = 0;
    int          test_errs   = 0;
    int          total;
    int          n_inst      = 0;
    logic        stall_en    = 1'b0;
    logic        done        = 1'b0;
    int          src [13]    = '{3, 4, 5, 6, 7, 8, 9, 11, 12, 13, 14, 15, 16};

    tb_clock_gen u_tb_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv32i u_rv32i (.*);

    bind rv32i rv32i_asserts u_asserts (.*);

    function automatic logic [31:0] r_type(input int sub, input int rs2, input int rs1,
                                           input int f3, input int rd);
        r_type = {1'b0, sub[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] opc);
        i_type = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        s_type = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        b_type = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                  7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd);
        u_type = {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    task automatic put(input logic [31:0] word);
        imem[n_inst] = word;
        n_inst++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic load_program();
        put(i_type(12, 0, 0, 1, op_imm));
        put(i_type(-7, 0, 0, 2, op_imm));
        put(u_type('h12345, 3));
        put(r_type(0, 2, 1, 0, 4));
        put(r_type(1, 2, 1, 0, 5));
        put(r_type(0, 2, 1, 7, 6));
        put(r_type(0, 2, 1, 6, 7));
        put(r_type(0, 2, 1, 4, 8));
        put(r_type(0, 1, 2, 2, 9));
        put(r_type(0, 1, 1, 1, 11));
        put(r_type(0, 1, 2, 5, 12));
        put(i_type('h0f0, 2, 7, 13, op_imm));
        put(i_type('h700, 1, 6, 14, op_imm));
        put(i_type(-1, 1, 4, 15, op_imm));
        put(i_type(-1, 1, 2, 16, op_imm));
        put(i_type('h200, 0, 0, 10, op_imm));
        for (int k = 0; k < 13; k++) begin
            put(s_type(4 * k, src[k], 10));
        end
        // dependent chain, then a write to x0
        put(i_type(5, 0, 0, 17, op_imm));
        put(r_type(0, 17, 17, 0, 18));
        put(r_type(1, 17, 18, 0, 19));
        put(i_type(9, 19, 0, 0, op_imm));
        put(r_type(0, 19, 0, 0, 20));
        put(s_type('h40, 18, 10));
        put(s_type('h44, 19, 10));
        put(s_type('h48, 20, 10));
        put(s_type('h4c, 0, 10));
        // loads with immediate use
        put(i_type('h100, 0, 0, 21, op_imm));
        put(i_type(0, 21, 2, 22, op_load));
        put(i_type(4, 21, 2, 23, op_load));
        put(r_type(0, 23, 22, 0, 24));
        put(s_type('h50, 24, 10));
        put(s_type('h154, 23, 21));
        // each store at offset 0x7c sits in a squashed slot
        put(i_type(7, 0, 0, 25, op_imm));
        put(i_type(7, 0, 0, 26, op_imm));
        put(b_type(8, 26, 25, 0));
        put(s_type('h7c, 25, 10));
        put(b_type(8, 26, 25, 1));
        put(s_type('h60, 25, 10));
        put(b_type(8, 0, 25, 1));
        put(s_type('h7c, 26, 10));
        put(b_type(8, 0, 25, 0));
        put(j_type(8, 27));
        put(s_type('h7c, 25, 10));
        put(s_type('h64, 27, 10));
        // back to the start for the stalled run
        put(j_type(-224, 0));
    endtask

    task automatic load_expected();
        expect_store('h200, 32'h1234_5000);
        expect_store('h204, 12 + (-7));
        expect_store('h208, 12 - (-7));
        expect_store('h20c, 32'h0000_0008);
        expect_store('h210, 32'hffff_fffd);
        expect_store('h214, 32'hffff_fff5);
        expect_store('h218, 32'd1);
        expect_store('h21c, 32'd12 << 12);
        expect_store('h220, 32'hffff_fff9 >> 12);
        expect_store('h224, 32'h0000_00f0);
        expect_store('h228, 32'h0000_070c);
        expect_store('h22c, ~32'd12);
        expect_store('h230, 32'd0);
        expect_store('h240, 32'd10);
        expect_store('h244, 32'd5);
        expect_store('h248, 32'd5);
        expect_store('h24c, 32'd0);
        expect_store('h250, 32'h1000 + 32'h234);
        expect_store('h254, 32'h0000_0234);
        expect_store('h260, 32'd7);
        // link of the jal at word 53
        expect_store('h264, 53 * 4 + 4);
    endtask

    initial begin
        void'($urandom(70522));
        stall_pipl    = 1'b0;
        inst          = '0;
        mem_rdata_mem = '0;
        for (int i = 0; i < imem_depth; i++) begin
            imem[i] = i_type(i, 0, 0, 0, op_imm);
        end
        for (int i = 0; i < dmem_depth; i++) begin
            dmem[i] = 32'h5a5a_0000 ^ (i * 4);
        end
        dmem['h40] = 32'h0000_1000;
        dmem['h41] = 32'h0000_0234;
        load_program();
        load_expected();

        wait (done || cycles >= timeout_cycles);
        if (!done) begin
            $display("timeout after %0d cycles, only %0d of %0d stores arrived",
                     cycles, stores_seen, 2 * stores_per_run);
            errors++;
        end
        total = errors + u_rv32i.u_asserts.fail_count;
        $display("%0d stores checked, %0d store errors, %0d assertion failures",
                 stores_seen, errors, u_rv32i.u_asserts.fail_count);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        inst   <= if_id_reg_en ? imem[current_pc[7:2]] : inst;
        stall_pipl <= stall_en && (($urandom % 4) == 0);
    end

    // data memory and store checking
    always @(posedge clk) begin
        int k;
        if (arst_n && !stall_pipl) begin
            if (mem_read_mem) begin
                mem_rdata_mem <= dmem[mem_addr_mem[9:2]];
            end
            if (mem_write_mem && !done) begin
                dmem[mem_addr_mem[9:2]] <= mem_wdata_mem;
                k = stores_seen % stores_per_run;
                assert (mem_addr_mem == exp_addr[k] && mem_wdata_mem == exp_data[k])
                else begin
                    $display("ERR %0t: store %0d at %h data %h, expected %h at %h", $time,
                             k, mem_addr_mem, mem_wdata_mem, exp_data[k], exp_addr[k]);
                    errors++;
                end
                if (k == test_last[test_idx]) begin
                    $display("run %0d test %s finished with %0d errors",
                             stores_seen / stores_per_run + 1, test_name[test_idx],
                             errors - test_errs);
                    test_errs = errors;
                    test_idx  = (test_idx + 1) % 4;
                end
                stores_seen++;
                if (stores_seen == stores_per_run) begin
                    stall_en <= 1'b1;
                end
                if (stores_seen == 2 * stores_per_run) begin
                    done = 1'b1;
                end
            end
        end
    end

endmodule

/* tb/rv32i_asserts.sv */
`timescale 1ns/1ns

module rv32i_asserts import rv32i_pkg::*; (
    input logic            clk,
    input logic            arst_n,
    input logic [xlen-1:0] current_pc,
    input logic [xlen-1:0] mem_addr_mem,
    input logic [xlen-1:0] mem_wdata_mem,
    input logic            mem_write_mem,
    input logic            mem_read_mem,
    input logic            stall_pipl,
    input logic            if_id_reg_en
);

    int fail_count = 0;

    // no memory access while the core is held in reset
    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !mem_write_mem && !mem_read_mem)
        else begin
            $error("memory strobe active during reset");
            fail_count++;
        end

    one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_write_mem && mem_read_mem))
        else begin
            $error("read and write strobes high together");
            fail_count++;
        end

    pc_aligned: assert property (@(posedge clk) current_pc[1:0] == 2'b00)
        else begin
            $error("fetch address not word aligned");
            fail_count++;
        end

    stall_fetch_off: assert property (@(posedge clk) disable iff (!arst_n)
        stall_pipl |-> !if_id_reg_en)
        else begin
            $error("fetch enabled during stall");
            fail_count++;
        end

    // a stalled edge leaves pc and the whole bus unchanged
    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        stall_pipl |=> $stable(current_pc) && $stable(mem_addr_mem) &&
                       $stable(mem_wdata_mem) && $stable(mem_write_mem) &&
                       $stable(mem_read_mem))
        else begin
            $error("pc or bus changed across a stall");
            fail_count++;
        end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    localparam int half_period  = 4;
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
    end

    always #half_period clk = ~clk;

    // reset released on a rising edge after the hold time
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

/* verilog/rv32i.sv */
`timescale 1ns/1ns

module rv32i import rv32i_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,

    // instruction memory
    output logic [xlen-1:0] current_pc,
    input  logic [xlen-1:0] inst,

    // data memory
    output logic [xlen-1:0] mem_addr_mem,
    output logic [xlen-1:0] mem_wdata_mem,
    output logic            mem_write_mem,
    output logic            mem_read_mem,
    input  logic [xlen-1:0] mem_rdata_mem,

    // bus stall
    input  logic            stall_pipl,
    output logic            if_id_reg_en
);

    // decoded control and hazard handling
    ctrl_t                 ctrl_ex;
    logic                  forward_rs1;
    logic                  forward_rs2;
    logic                  ex_valid_clr;
    logic                  pipe_en;

    // execute fields and writeback record back to the controller
    opcode_e               opcode_ex;
    logic [2:0]            funct3_ex;
    logic                  funct7_5_ex;
    logic [reg_addr_w-1:0] rs1_ex;
    logic [reg_addr_w-1:0] rs2_ex;
    wb_t                   wb_stage;
    logic                  pc_sel_ex;

    data_path u_data_path (
        .clk           (clk),
        .arst_n        (arst_n),
        .inst          (inst),
        .current_pc    (current_pc),
        .ctrl_ex       (ctrl_ex),
        .forward_rs1   (forward_rs1),
        .forward_rs2   (forward_rs2),
        .ex_valid_clr  (ex_valid_clr),
        .pipe_en       (pipe_en),
        .opcode_ex     (opcode_ex),
        .funct3_ex     (funct3_ex),
        .funct7_5_ex   (funct7_5_ex),
        .rs1_ex        (rs1_ex),
        .rs2_ex        (rs2_ex),
        .wb_stage      (wb_stage),
        .pc_sel_ex     (pc_sel_ex),
        .mem_addr_mem  (mem_addr_mem),
        .mem_wdata_mem (mem_wdata_mem),
        .mem_write_mem (mem_write_mem),
        .mem_read_mem  (mem_read_mem),
        .mem_rdata_mem (mem_rdata_mem)
    );

    control_unit u_control_unit (
        .opcode_ex    (opcode_ex),
        .funct3_ex    (funct3_ex),
        .funct7_5_ex  (funct7_5_ex),
        .rs1_ex       (rs1_ex),
        .rs2_ex       (rs2_ex),
        .wb_stage     (wb_stage),
        .pc_sel_ex    (pc_sel_ex),
        .stall_pipl   (stall_pipl),
        .ctrl_ex      (ctrl_ex),
        .forward_rs1  (forward_rs1),
        .forward_rs2  (forward_rs2),
        .ex_valid_clr (ex_valid_clr),
        .pipe_en      (pipe_en),
        .if_id_reg_en (if_id_reg_en)
    );

endmodule

/* verilog/data_path.sv */
`timescale 1ns/1ns

module data_path import rv32i_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [xlen-1:0]       inst,
    output logic [xlen-1:0]       current_pc,
    input  ctrl_t                 ctrl_ex,
    input  logic                  forward_rs1,
    input  logic                  forward_rs2,
    input  logic                  ex_valid_clr,
    input  logic                  pipe_en,
    output opcode_e               opcode_ex,
    output logic [2:0]            funct3_ex,
    output logic                  funct7_5_ex,
    output logic [reg_addr_w-1:0] rs1_ex,
    output logic [reg_addr_w-1:0] rs2_ex,
    output wb_t                   wb_stage,
    output logic                  pc_sel_ex,
    output logic [xlen-1:0]       mem_addr_mem,
    output logic [xlen-1:0]       mem_wdata_mem,
    output logic                  mem_write_mem,
    output logic                  mem_read_mem,
    input  logic [xlen-1:0]       mem_rdata_mem
);

    logic [xlen-1:0]       pc_ex;
    logic                  valid_ex;
    logic [reg_addr_w-1:0] rd_ex;
    logic [xlen-1:0]       imm_i, imm_s, imm_b, imm_j, imm_u;
    logic [xlen-1:0]       imm_op;
    logic [xlen-1:0]       rf_rd1, rf_rd2;
    logic [xlen-1:0]       op_a, op_b, src2;
    logic [xlen-1:0]       alu_y;
    logic                  alu_zero;
    logic [xlen-1:0]       target, link;
    logic [xlen-1:0]       wb_data;
    logic                  rf_we;

    // fields of the instruction now in execute
    assign opcode_ex   = opcode_e'(inst[6:0]);
    assign funct3_ex   = inst[14:12];
    assign funct7_5_ex = inst[30];
    assign rs1_ex      = inst[19:15];
    assign rs2_ex      = inst[24:20];
    assign rd_ex       = inst[11:7];

    // immediates
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        if (ctrl_ex.lui) begin
            imm_op = imm_u;
        end else if (ctrl_ex.mem_write) begin
            imm_op = imm_s;
        end else begin
            imm_op = imm_i;
        end
    end

    // loads are resolved here so forwarding sees the bus data
    assign wb_data = wb_stage.mem_to_reg ? mem_rdata_mem : wb_stage.result;
    assign rf_we   = pipe_en && wb_stage.valid && wb_stage.reg_write;

    reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (rs1_ex),
        .rs2    (rs2_ex),
        .rd     (wb_stage.rd),
        .we     (rf_we),
        .wdata  (wb_data),
        .rd1    (rf_rd1),
        .rd2    (rf_rd2)
    );

    assign op_a = forward_rs1 ? wb_data : rf_rd1;
    assign src2 = forward_rs2 ? wb_data : rf_rd2;
    assign op_b = ctrl_ex.alu_src ? imm_op : src2;

    alu u_alu (
        .a    (op_a),
        .b    (op_b),
        .op   (ctrl_ex.alu_op),
        .y    (alu_y),
        .zero (alu_zero)
    );

    // branch and jump resolution
    assign target    = pc_ex + (ctrl_ex.jump ? imm_j : imm_b);
    assign link      = pc_ex + 32'd4;
    assign pc_sel_ex = valid_ex &&
                       (ctrl_ex.jump || (ctrl_ex.branch && (alu_zero ^ ctrl_ex.branch_ne)));

    // data memory bus
    assign mem_addr_mem  = alu_y;
    assign mem_wdata_mem = src2;
    assign mem_write_mem = valid_ex && ctrl_ex.mem_write;
    assign mem_read_mem  = valid_ex && ctrl_ex.mem_to_reg;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            current_pc <= reset_pc;
            valid_ex   <= 1'b0;
        end else if (pipe_en) begin
            current_pc <= pc_sel_ex ? target : current_pc + 32'd4;
            valid_ex   <= !ex_valid_clr;
        end
    end

    // pc of the fetched word follows it into execute
    always_ff @(posedge clk) begin
        if (pipe_en) begin
            pc_ex <= current_pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_stage <= '0;
        end else if (pipe_en) begin
            wb_stage.valid      <= valid_ex;
            wb_stage.reg_write  <= ctrl_ex.reg_write;
            wb_stage.mem_to_reg <= ctrl_ex.mem_to_reg;
            wb_stage.rd         <= rd_ex;
            wb_stage.result     <= ctrl_ex.jump ? link : alu_y;
        end
    end

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ns

module control_unit import rv32i_pkg::*; (
    input  opcode_e               opcode_ex,
    input  logic [2:0]            funct3_ex,
    input  logic                  funct7_5_ex,
    input  logic [reg_addr_w-1:0] rs1_ex,
    input  logic [reg_addr_w-1:0] rs2_ex,
    input  wb_t                   wb_stage,
    input  logic                  pc_sel_ex,
    input  logic                  stall_pipl,
    output ctrl_t                 ctrl_ex,
    output logic                  forward_rs1,
    output logic                  forward_rs2,
    output logic                  ex_valid_clr,
    output logic                  pipe_en,
    output logic                  if_id_reg_en
);

    // alu operation picked by funct3 for r-type and i-type
    alu_op_e arith_op;
    logic    wb_writes;

    always_comb begin
        case (funct3_ex)
            3'b000: begin
                // sub only exists in r-type
                if (opcode_ex == op_r && funct7_5_ex) begin
                    arith_op = alu_sub;
                end else begin
                    arith_op = alu_add;
                end
            end
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alu_srl;
            3'b110:  arith_op = alu_or;
            3'b111:  arith_op = alu_and;
            default: arith_op = alu_add;
        endcase
    end

    always_comb begin
        ctrl_ex        = '0;
        ctrl_ex.alu_op = alu_add;
        case (opcode_ex)
            op_r: begin
                ctrl_ex.reg_write = 1'b1;
                ctrl_ex.alu_op    = arith_op;
            end
            op_imm: begin
                ctrl_ex.reg_write = 1'b1;
                ctrl_ex.alu_src   = 1'b1;
                ctrl_ex.alu_op    = arith_op;
            end
            op_lui: begin
                ctrl_ex.reg_write = 1'b1;
                ctrl_ex.alu_src   = 1'b1;
                ctrl_ex.lui       = 1'b1;
                ctrl_ex.alu_op    = alu_pass_b;
            end
            op_load: begin
                ctrl_ex.reg_write  = 1'b1;
                ctrl_ex.mem_to_reg = 1'b1;
                ctrl_ex.alu_src    = 1'b1;
            end
            op_store: begin
                ctrl_ex.mem_write = 1'b1;
                ctrl_ex.alu_src   = 1'b1;
            end
            op_branch: begin
                // funct3 bit 0 separates bne from beq
                ctrl_ex.branch    = 1'b1;
                ctrl_ex.branch_ne = funct3_ex[0];
                ctrl_ex.alu_op    = alu_sub;
            end
            op_jal: begin
                ctrl_ex.reg_write = 1'b1;
                ctrl_ex.jump      = 1'b1;
            end
            default: ctrl_ex = '0;
        endcase
    end

    // writeback result is forwarded when it targets a nonzero source
    assign wb_writes   = wb_stage.valid && wb_stage.reg_write;
    assign forward_rs1 = wb_writes && (rs1_ex != '0) && (wb_stage.rd == rs1_ex);
    assign forward_rs2 = wb_writes && (rs2_ex != '0) && (wb_stage.rd == rs2_ex);

    // squash the instruction fetched behind a taken branch or jump
    assign ex_valid_clr = pc_sel_ex;

    assign pipe_en      = !stall_pipl;
    assign if_id_reg_en = !stall_pipl;

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ns

module reg_file import rv32i_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic [reg_addr_w-1:0] rd,
    input  logic                  we,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rd1,
    output logic [xlen-1:0]       rd2
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ns

module alu import rv32i_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] y,
    output logic            zero
);

    // shift amount is the low five bits of the second operand
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:    y = a + b;
            alu_sub:    y = a - b;
            alu_and:    y = a & b;
            alu_or:     y = a | b;
            alu_xor:    y = a ^ b;
            // signed compare, result is 0 or 1
            alu_slt:    y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sll:    y = a << shamt;
            alu_srl:    y = a >> shamt;
            alu_pass_b: y = b;
            default:    y = '0;
        endcase
    end

    // used by beq and bne after a subtract
    assign zero = (y == '0);

endmodule

/* verilog/rv32i_pkg.sv */
package rv32i_pkg;

    // machine word and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = '0;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    // alu operations
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sll    = 4'd6,
        alu_srl    = 4'd7,
        alu_pass_b = 4'd8
    } alu_op_e;

    // decoded control of the instruction in execute
    typedef struct packed {
        logic    reg_write;
        logic    mem_write;
        logic    mem_to_reg;
        logic    branch;
        logic    branch_ne;
        logic    jump;
        logic    alu_src;
        logic    lui;
        alu_op_e alu_op;
    } ctrl_t;

    // writeback stage register
    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic                  mem_to_reg;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
    } wb_t;

endpackage
